/* project.f */
hw/id_remap_pkg.sv
hw/id_remap_table.sv
hw/aw_issue_stage.sv
hw/id_remap_top.sv
test/id_remap_assertions.sv
test/tb_id_remap.sv

/* Bender.yml */
package:
  name: id_remap

sources:
  - files:
      - hw/id_remap_pkg.sv
      - hw/id_remap_table.sv
      - hw/aw_issue_stage.sv
      - hw/id_remap_top.sv
  - target: test
    files:
      - test/id_remap_assertions.sv
      - test/tb_id_remap.sv

/* test/tb_id_remap.sv */
`timescale 1ns/1ps

module tb_id_remap import id_remap_pkg::*; ();

  localparam int unsigned NumRandom = 300;
  // About six cycles per burst, plus the two hold phases and reset.
  localparam time TrafficNs = (NumRandom + 9) * 60 + 1000;

  logic    clk_i;
  logic    rst_ni;
  slv_aw_t slv_aw_i;
  logic    slv_aw_valid_i;
  logic    slv_aw_ready_o;
  slv_b_t  slv_b_o;
  logic    slv_b_valid_o;
  logic    slv_b_ready_i;
  mst_aw_t mst_aw_o;
  logic    mst_aw_valid_o;
  logic    mst_aw_ready_i;
  mst_b_t  mst_b_i;
  logic    mst_b_valid_i;
  logic    mst_b_ready_o;

  // Bursts taken by the model slave and still waiting for their B response.
  mst_aw_t     aw_q[$];
  slv_id_t     id_plan[$];
  int unsigned planned;
  int unsigned accepted;
  int unsigned b_count;
  int unsigned tb_errors;
  logic        b_held;

  id_remap_top #(.TableSize(4), .MaxTxnsPerId(3)) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic plan_burst(input slv_id_t id);
    id_plan.push_back(id);
    planned++;
  endtask

  // One clock cycle of traffic.
  // Handshakes are sampled at the falling edge, where every signal has settled.
  task automatic step();
    logic    aw_done;
    logic    b_done;
    int      idx;
    mst_id_t b_id;
    @(negedge clk_i);
    aw_done = slv_aw_valid_i && slv_aw_ready_o;
    b_done  = mst_b_valid_i && mst_b_ready_o;
    if (mst_aw_valid_o && mst_aw_ready_i) begin
      aw_q.push_back(mst_aw_o);
    end
    @(posedge clk_i);
    #1;
    if (aw_done) begin
      slv_aw_valid_i = 1'b0;
      accepted++;
    end
    if (!slv_aw_valid_i && id_plan.size() != 0) begin
      slv_aw_i.id    = id_plan.pop_front();
      slv_aw_i.addr  = $urandom();
      slv_aw_i.len   = len_t'($urandom_range(0, 255));
      slv_aw_valid_i = 1'b1;
    end
    // The downstream slave stalls AW about a quarter of the time.
    mst_aw_ready_i = ($urandom_range(0, 3) != 0);
    if (b_done) begin
      mst_b_valid_i = 1'b0;
      b_count++;
    end
    if (!mst_b_valid_i && !b_held && aw_q.size() != 0 && $urandom_range(0, 1) == 1) begin
      // Any master ID may answer next, but only with its oldest burst.
      idx  = $urandom_range(0, aw_q.size() - 1);
      b_id = aw_q[idx].id;
      for (int i = idx; i >= 0; i--) begin
        if (aw_q[i].id == b_id) begin
          idx = i;
        end
      end
      mst_b_i.id    = b_id;
      mst_b_i.resp  = resp_t'($urandom());
      mst_b_valid_i = 1'b1;
      aw_q.delete(idx);
    end
    slv_b_ready_i = ($urandom_range(0, 3) != 0);
  endtask

  // Runs until every planned burst is accepted and answered.
  task automatic drain();
    while (accepted < planned || aw_q.size() != 0 || mst_b_valid_i) begin
      step();
    end
  endtask

  initial begin
    void'($urandom(32'ha5d4_58f1));
    rst_ni         = 1'b0;
    slv_aw_i       = '0;
    slv_aw_valid_i = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_b_i        = '0;
    mst_b_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    planned        = 0;
    accepted       = 0;
    b_count        = 0;
    tb_errors      = 0;
    b_held         = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    repeat (2) step();

    // One slave ID runs into its limit, so the fourth burst has to wait.
    b_held = 1'b1;
    repeat (4) plan_burst(slv_id_t'(5));
    repeat (30) step();
    b_held = 1'b0;
    drain();

    // Four distinct slave IDs occupy the whole table and a fifth one waits.
    b_held = 1'b1;
    for (int i = 0; i < 5; i++) begin
      plan_burst(slv_id_t'(i));
    end
    repeat (30) step();
    b_held = 1'b0;
    drain();

    for (int i = 0; i < NumRandom; i++) begin
      plan_burst(slv_id_t'($urandom_range(0, 7)));
    end
    drain();
    repeat (3) step();

    if (b_count != accepted) begin
      tb_errors++;
      $display("ERROR %0t B handshakes: expected %0d, got %0d", $time, accepted, b_count);
    end
    $display("Errors: %0d from assertions, %0d from the testbench",
             dut_i.asrt_i.err_cnt, tb_errors);
    if (dut_i.asrt_i.err_cnt == 0 && tb_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Stops a stuck run at three times the expected traffic time.
  initial begin
    #(3 * TrafficNs);
    $display("Timeout: the traffic did not finish within %0d ns", 3 * TrafficNs);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* test/id_remap_assertions.sv */
`timescale 1ns/1ps

module id_remap_assertions import id_remap_pkg::*; #(
  parameter int unsigned TableSize    = 4,
  parameter int unsigned MaxTxnsPerId = 3
) (
  input logic    clk_i,
  input logic    rst_ni,
  input slv_aw_t slv_aw_i,
  input logic    slv_aw_valid_i,
  input logic    slv_aw_ready_o,
  input slv_b_t  slv_b_o,
  input logic    slv_b_valid_o,
  input logic    slv_b_ready_i,
  input mst_aw_t mst_aw_o,
  input logic    mst_aw_valid_o,
  input logic    mst_aw_ready_i,
  input mst_b_t  mst_b_i,
  input logic    mst_b_valid_i,
  input logic    mst_b_ready_o
);

  int unsigned err_cnt = 0;
  // Shadow map of master ID to slave ID and number of bursts in flight.
  slv_id_t     shadow_slv [TableSize];
  int unsigned shadow_cnt [TableSize];
  logic        held_q;
  mst_id_t     held_id_q;
  logic        aw_hs;
  logic        b_hs;
  logic        fresh;
  logic        admit;
  mst_id_t     exp_id;

  assign aw_hs = mst_aw_valid_o && mst_aw_ready_i;
  assign b_hs  = slv_b_valid_o && slv_b_ready_i;
  // A fresh offer is one that was not already stalled in the cycle before.
  assign fresh = mst_aw_valid_o && !held_q;

  // The lowest idle master ID is the default choice.
  // A slave ID that is still in flight overrides it with its own master ID.
  always_comb begin
    admit  = 1'b0;
    exp_id = '0;
    for (int i = TableSize - 1; i >= 0; i--) begin
      if (shadow_cnt[i] == 0) begin
        exp_id = mst_id_t'(i);
        admit  = 1'b1;
      end
    end
    for (int i = 0; i < TableSize; i++) begin
      if (shadow_cnt[i] != 0 && shadow_slv[i] == slv_aw_i.id) begin
        exp_id = mst_id_t'(i);
        admit  = (shadow_cnt[i] < MaxTxnsPerId);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q    <= 1'b0;
      held_id_q <= '0;
      for (int i = 0; i < TableSize; i++) begin
        shadow_slv[i] <= '0;
        shadow_cnt[i] <= 0;
      end
    end else begin
      held_q    <= mst_aw_valid_o && !mst_aw_ready_i;
      held_id_q <= mst_aw_o.id;
      for (int i = 0; i < TableSize; i++) begin
        if (aw_hs && mst_aw_o.id == mst_id_t'(i)) begin
          shadow_slv[i] <= slv_aw_i.id;
        end
        shadow_cnt[i] <= shadow_cnt[i] + (aw_hs && mst_aw_o.id == mst_id_t'(i))
                         - (b_hs && mst_b_i.id == mst_id_t'(i));
      end
    end
  end

  // Both AW handshakes coincide, and address and length pass through.
  a_aw_pass: assert property (@(posedge clk_i) disable iff (!rst_ni)
      aw_hs |-> slv_aw_valid_i && slv_aw_ready_o
                && {mst_aw_o.addr, mst_aw_o.len} == {slv_aw_i.addr, slv_aw_i.len})
    else begin
      err_cnt++;
      $error("ERROR %0t mst_aw_o.addr/len/slv_aw_ready_o: expected %h/1, got %h/%0b", $time,
             $sampled({slv_aw_i.addr, slv_aw_i.len}),
             $sampled({mst_aw_o.addr, mst_aw_o.len}), $sampled(slv_aw_ready_o));
    end

  // A stalled AW stays offered with the same master ID.
  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      held_q |-> mst_aw_valid_o && mst_aw_o.id == held_id_q)
    else begin
      err_cnt++;
      $error("ERROR %0t mst_aw_o.id: expected %0d, got %0d (valid %0b)", $time,
             $sampled(held_id_q), $sampled(mst_aw_o.id), $sampled(mst_aw_valid_o));
    end

  a_aw_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fresh |-> mst_aw_o.id == exp_id)
    else begin
      err_cnt++;
      $error("ERROR %0t mst_aw_o.id: expected %0d, got %0d", $time,
             $sampled(exp_id), $sampled(mst_aw_o.id));
    end

  // Nothing goes out for an ID at its limit, or for a new ID while all entries are busy.
  a_aw_admit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fresh |-> admit)
    else begin
      err_cnt++;
      $error("ERROR %0t mst_aw_valid_o: expected 0, got 1 for slave ID %0d", $time,
             $sampled(slv_aw_i.id));
    end

  a_b_back: assert property (@(posedge clk_i) disable iff (!rst_ni)
      b_hs |-> slv_b_o == {shadow_slv[mst_b_i.id], mst_b_i.resp})
    else begin
      err_cnt++;
      $error("ERROR %0t slv_b_o: expected %h, got %h", $time,
             $sampled({shadow_slv[mst_b_i.id], mst_b_i.resp}), $sampled(slv_b_o));
    end

  // Valid and ready of the B channel pass straight through.
  a_b_pass: assert property (@(posedge clk_i) disable iff (!rst_ni)
      slv_b_valid_o == mst_b_valid_i && mst_b_ready_o == slv_b_ready_i)
    else begin
      err_cnt++;
      $error("ERROR %0t slv_b_valid_o/mst_b_ready_o: expected %0b/%0b, got %0b/%0b", $time,
             $sampled(mst_b_valid_i), $sampled(slv_b_ready_i),
             $sampled(slv_b_valid_o), $sampled(mst_b_ready_o));
    end

  // The AW outputs stay idle during reset and in the first cycle after it.
  a_reset: assert property (@(posedge clk_i)
      !rst_ni |-> (!mst_aw_valid_o && !slv_aw_ready_o) ##1 (!mst_aw_valid_o && !slv_aw_ready_o))
    else begin
      err_cnt++;
      $error("ERROR %0t mst_aw_valid_o/slv_aw_ready_o: expected 0/0, got %0b/%0b", $time,
             $sampled(mst_aw_valid_o), $sampled(slv_aw_ready_o));
    end

endmodule

bind id_remap_top id_remap_assertions #(
  .TableSize    (TableSize),
  .MaxTxnsPerId (MaxTxnsPerId)
) asrt_i (.*);

/* hw/id_remap_top.sv */
`timescale 1ns/1ps

module id_remap_top import id_remap_pkg::*; #(
  parameter int unsigned TableSize    = 4,
  parameter int unsigned MaxTxnsPerId = 3
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Slave port, facing the upstream master.
  input  slv_aw_t slv_aw_i,
  input  logic    slv_aw_valid_i,
  output logic    slv_aw_ready_o,
  output slv_b_t  slv_b_o,
  output logic    slv_b_valid_o,
  input  logic    slv_b_ready_i,
  // Master port, facing the downstream slave.
  output mst_aw_t mst_aw_o,
  output logic    mst_aw_valid_o,
  input  logic    mst_aw_ready_i,
  input  mst_b_t  mst_b_i,
  input  logic    mst_b_valid_i,
  output logic    mst_b_ready_o
);

  logic    match;
  mst_id_t match_mst_id;
  logic    match_full;
  logic    full;
  mst_id_t free_mst_id;
  logic    push;
  slv_id_t push_slv_id;
  mst_id_t push_mst_id;
  logic    pop;
  slv_id_t pop_slv_id;

  aw_issue_stage aw_issue_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .match_i        (match),
    .match_mst_id_i (match_mst_id),
    .match_full_i   (match_full),
    .full_i         (full),
    .free_mst_id_i  (free_mst_id),
    .push_o         (push),
    .push_slv_id_o  (push_slv_id),
    .push_mst_id_o  (push_mst_id)
  );

  // The lookup always uses the ID on the slave AW channel.
  // In Hold the issue stage ignores the result.
  id_remap_table #(
    .TableSize    (TableSize),
    .MaxTxnsPerId (MaxTxnsPerId)
  ) table_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_slv_id_i  (push_slv_id),
    .push_mst_id_i  (push_mst_id),
    .lookup_id_i    (slv_aw_i.id),
    .pop_i          (pop),
    .pop_mst_id_i   (mst_b_i.id),
    .match_o        (match),
    .match_mst_id_o (match_mst_id),
    .match_full_o   (match_full),
    .full_o         (full),
    .free_mst_id_o  (free_mst_id),
    .pop_slv_id_o   (pop_slv_id)
  );

  // The B channel is combinational in both directions.
  // An entry is released once the response is handed to the slave port.
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;
  assign pop           = slv_b_valid_o && slv_b_ready_i;
  assign slv_b_o.id    = pop_slv_id;
  assign slv_b_o.resp  = mst_b_i.resp;

endmodule

/* hw/aw_issue_stage.sv */
`timescale 1ns/1ps

module aw_issue_stage import id_remap_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  slv_aw_t slv_aw_i,
  input  logic    slv_aw_valid_i,
  output logic    slv_aw_ready_o,
  output mst_aw_t mst_aw_o,
  output logic    mst_aw_valid_o,
  input  logic    mst_aw_ready_i,
  input  logic    match_i,
  input  mst_id_t match_mst_id_i,
  input  logic    match_full_i,
  input  logic    full_i,
  input  mst_id_t free_mst_id_i,
  output logic    push_o,
  output slv_id_t push_slv_id_o,
  output mst_id_t push_mst_id_o
);

  issue_state_e state_d, state_q;
  mst_id_t      hold_id_d, hold_id_q;
  mst_id_t      chosen_id;
  mst_id_t      aw_id;
  logic         admissible;

  // A slave ID already in flight must reuse its master ID to keep its bursts ordered.
  // A new slave ID needs any free entry.
  assign admissible = match_i ? !match_full_i : !full_i;
  assign chosen_id  = match_i ? match_mst_id_i : free_mst_id_i;

  always_comb begin
    state_d        = state_q;
    hold_id_d      = hold_id_q;
    aw_id          = chosen_id;
    mst_aw_valid_o = 1'b0;
    slv_aw_ready_o = 1'b0;
    push_o         = 1'b0;

    unique case (state_q)
      Ready: begin
        // Forward the burst in the same cycle and book it in the table right away.
        if (slv_aw_valid_i && admissible) begin
          mst_aw_valid_o = 1'b1;
          slv_aw_ready_o = mst_aw_ready_i;
          push_o         = 1'b1;
          // The master stalls, so remember the chosen ID.
          // The table has already moved on and its lookup may now say otherwise.
          if (!mst_aw_ready_i) begin
            hold_id_d = chosen_id;
            state_d   = Hold;
          end
        end
      end

      Hold: begin
        // The burst was pushed when it was first offered.
        // Only the handshake is still open here.
        aw_id          = hold_id_q;
        mst_aw_valid_o = 1'b1;
        slv_aw_ready_o = mst_aw_ready_i;
        if (mst_aw_ready_i) begin
          state_d = Ready;
        end
      end

      default: begin
        state_d = Ready;
      end
    endcase
  end

  // Address and length pass through, and only the ID is replaced.
  assign mst_aw_o.id   = aw_id;
  assign mst_aw_o.addr = slv_aw_i.addr;
  assign mst_aw_o.len  = slv_aw_i.len;

  // The table only takes these while push_o is high.
  assign push_slv_id_o = slv_aw_i.id;
  assign push_mst_id_o = chosen_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Ready;
    end else begin
      state_q <= state_d;
    end
  end

  // The held ID is captured on the way into Hold and drives the master port there.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_id_q <= '0;
    end else begin
      hold_id_q <= hold_id_d;
    end
  end

endmodule

/* hw/id_remap_table.sv */
`timescale 1ns/1ps

module id_remap_table import id_remap_pkg::*; #(
  parameter int unsigned TableSize    = 4,
  parameter int unsigned MaxTxnsPerId = 3
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    push_i,
  input  slv_id_t push_slv_id_i,
  input  mst_id_t push_mst_id_i,
  input  slv_id_t lookup_id_i,
  input  logic    pop_i,
  input  mst_id_t pop_mst_id_i,
  output logic    match_o,
  output mst_id_t match_mst_id_o,
  output logic    match_full_o,
  output logic    full_o,
  output mst_id_t free_mst_id_o,
  output slv_id_t pop_slv_id_o
);

  // The counter must reach MaxTxnsPerId itself, hence the extra value.
  localparam int unsigned CntWidth = $clog2(MaxTxnsPerId + 1);

  typedef logic [CntWidth-1:0]  cnt_t;
  typedef logic [TableSize-1:0] vec_t;

  // One entry per master ID.
  // A count of zero means the master ID is free and its slave ID is stale.
  typedef struct packed {
    slv_id_t slv_id;
    cnt_t    cnt;
  } entry_t;

  entry_t [TableSize-1:0] table_d, table_q;
  vec_t                   free_vec;
  vec_t                   match_vec;

  // Priority encoder that returns the index of the lowest set bit.
  // The loop runs downwards so the lowest set bit is written last.
  function automatic mst_id_t lowest_set(input vec_t vec);
    mst_id_t idx;
    idx = '0;
    for (int i = TableSize - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = mst_id_t'(i);
      end
    end
    return idx;
  endfunction

  // An entry is free when nothing is in flight on its master ID.
  // It matches when bursts are in flight and it carries the looked-up slave ID.
  always_comb begin
    for (int i = 0; i < TableSize; i++) begin
      free_vec[i]  = (table_q[i].cnt == '0);
      match_vec[i] = (table_q[i].cnt != '0) && (table_q[i].slv_id == lookup_id_i);
    end
  end

  // Lowest free master ID, only meaningful while the table is not full.
  assign free_mst_id_o = lowest_set(free_vec);
  assign full_o        = ~|free_vec;

  // A slave ID lives in at most one entry, so the match vector is one-hot or empty.
  assign match_mst_id_o = lowest_set(match_vec);
  assign match_o        = |match_vec;

  // The limit flag is taken from the matching entry only.
  always_comb begin
    match_full_o = 1'b0;
    for (int i = 0; i < TableSize; i++) begin
      if (match_vec[i] && (table_q[i].cnt == cnt_t'(MaxTxnsPerId))) begin
        match_full_o = 1'b1;
      end
    end
  end

  // Translate a returning master ID back to its slave ID.
  // IDs outside the table read as zero.
  always_comb begin
    pop_slv_id_o = '0;
    for (int i = 0; i < TableSize; i++) begin
      if (pop_mst_id_i == mst_id_t'(i)) begin
        pop_slv_id_o = table_q[i].slv_id;
      end
    end
  end

  // Push and pop may target the same entry in one cycle.
  // The two updates then cancel in the count, and the slave ID is rewritten unchanged.
  always_comb begin
    table_d = table_q;
    for (int i = 0; i < TableSize; i++) begin
      if (push_i && (push_mst_id_i == mst_id_t'(i))) begin
        table_d[i].slv_id = push_slv_id_i;
        table_d[i].cnt    = table_d[i].cnt + 1'b1;
      end
      if (pop_i && (pop_mst_id_i == mst_id_t'(i))) begin
        table_d[i].cnt = table_d[i].cnt - 1'b1;
      end
    end
  end

  // All entries start free.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      table_q <= '0;
    end else begin
      table_q <= table_d;
    end
  end

endmodule

/* hw/id_remap_pkg.sv */
package id_remap_pkg;

  // Width of the IDs seen by the upstream master on the slave port.
  localparam int unsigned SlvIdWidth = 4;
  // Width of the IDs issued downstream on the master port.
  // It also sets the largest table that can be built, four entries.
  localparam int unsigned MstIdWidth = 2;
  // Burst address width, identical on both ports.
  localparam int unsigned AddrWidth  = 32;

  typedef logic [SlvIdWidth-1:0] slv_id_t;
  // A master-side ID doubles as the index into the remap table.
  typedef logic [MstIdWidth-1:0] mst_id_t;
  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [7:0]            len_t;
  typedef logic [1:0]            resp_t;

  // Write address beat as it enters on the slave port.
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_aw_t;

  // Write address beat as it leaves on the master port, with the remapped ID.
  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_aw_t;

  typedef struct packed {
    slv_id_t id;
    resp_t   resp;
  } slv_b_t;

  typedef struct packed {
    mst_id_t id;
    resp_t   resp;
  } mst_b_t;

  // Ready issues new bursts, Hold keeps a stalled burst on the master port.
  typedef enum logic {Ready, Hold} issue_state_e;

endpackage
